// ==== source/mem_port_pkg.sv ====
// Memory port widths and the request and response structs
package mem_port_pkg;

  // Word address and data widths of the read port
  localparam int MEM_AW = 16;
  localparam int MEM_DW = 32;

  // Request strobe with word address; held until granted
  typedef struct packed {
    logic              req;
    logic [MEM_AW-1:0] addr;
  } mem_req_t;

  // Same-cycle grant, later response strobe with data
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [MEM_DW-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== source/streamer_pkg.sv ====
// Operand sizes, job and pair structs, load FSM states
package streamer_pkg;

  // Element and lane sizes
  localparam int X_ITEM_W         = 8;
  localparam int Y_ITEM_W         = 8;
  localparam int X_ELEMS_PER_WORD = mem_port_pkg::MEM_DW / X_ITEM_W;
  localparam int Y_LANES          = 4;

  // Counter and field widths
  localparam int LANE_CNT_W = 3;
  localparam int XCNT_W     = 8;
  localparam int ELEM_IDX_W = $clog2(X_ELEMS_PER_WORD);
  localparam int ELEM_CNT_W = ELEM_IDX_W + 1;

  // Number of load FSM states, for the one-hot decode
  localparam int LOAD_STATE_N = 5;

  // Job description; x_words must not be zero
  typedef struct packed {
    logic [mem_port_pkg::MEM_AW-1:0] meta_addr;
    logic [mem_port_pkg::MEM_AW-1:0] x_addr;
    logic [mem_port_pkg::MEM_AW-1:0] y_addr;
    logic [XCNT_W-1:0]               x_words;
  } job_cfg_t;

  // One X element paired with one masked Y word
  typedef struct packed {
    logic [X_ITEM_W-1:0]             x;
    logic [mem_port_pkg::MEM_DW-1:0] y;
  } operand_pair_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_META,
    LOAD_X,
    LOAD_Y,
    WAIT_PAIR
  } load_state_e;

endpackage

// ==== source/load_addr_gen.sv ====
// Address counters for the metadata, X and Y operands of a job
`timescale 1ns/10ps

module load_addr_gen (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  streamer_pkg::job_cfg_t           job_i,
  input  streamer_pkg::load_state_e        state_i,
  input  logic                             gnt_i,
  output logic [mem_port_pkg::MEM_AW-1:0]  addr_o,
  output logic                             last_x_o,
  output logic                             last_elem_o
);

  import mem_port_pkg::*;
  import streamer_pkg::*;

  logic [MEM_AW-1:0]     meta_addr_q;
  logic [MEM_AW-1:0]     x_ptr_q;
  logic [MEM_AW-1:0]     y_ptr_q;
  logic [XCNT_W-1:0]     x_left_q;
  logic [ELEM_CNT_W-1:0] elem_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_addr_q <= '0;
      x_ptr_q     <= '0;
      y_ptr_q     <= '0;
      x_left_q    <= '0;
      elem_cnt_q  <= '0;
    end else if (state_i == IDLE) begin
      // Job is taken only while idle
      if (start_i) begin
        meta_addr_q <= job_i.meta_addr;
        x_ptr_q     <= job_i.x_addr;
        y_ptr_q     <= job_i.y_addr;
        x_left_q    <= job_i.x_words;
        elem_cnt_q  <= '0;
      end
    end else if (gnt_i) begin
      if (state_i == LOAD_X) begin
        x_ptr_q    <= x_ptr_q + MEM_AW'(1);
        x_left_q   <= x_left_q - XCNT_W'(1);
        elem_cnt_q <= '0;
      end else if (state_i == LOAD_Y) begin
        // Y walks one word per element, across X word boundaries
        y_ptr_q    <= y_ptr_q + MEM_AW'(1);
        elem_cnt_q <= elem_cnt_q + ELEM_CNT_W'(1);
      end
    end
  end

  always_comb begin
    case (state_i)
      LOAD_META: addr_o = meta_addr_q;
      LOAD_X:    addr_o = x_ptr_q;
      LOAD_Y:    addr_o = y_ptr_q;
      default:   addr_o = '0;
    endcase
  end

  // Counts are taken after the grant of the current word
  assign last_x_o    = (x_left_q == '0);
  assign last_elem_o = (elem_cnt_q == ELEM_CNT_W'(X_ELEMS_PER_WORD));

  // Memory only grants requests raised by the FSM
  a_no_gnt_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> (state_i != IDLE)
  );

endmodule

// ==== source/load_fsm.sv ====
// Load sequencer for the metadata, X and Y phases
// Also drives the memory request strobe and the job status
`timescale 1ns/10ps

module load_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic                      rvalid_i,
  input  logic                      gnt_i,
  input  logic                      pair_accept_i,
  input  logic                      last_x_i,
  input  logic                      last_elem_i,
  output streamer_pkg::load_state_e state_o,
  output logic                      req_o,
  output logic                      busy_o,
  output logic                      done_o
);

  import streamer_pkg::*;

  load_state_e             state_q;
  load_state_e             state_d;
  logic                    pend_q;
  logic                    req_set;
  logic                    rsp_wait_q;
  logic                    rsp_done;
  logic                    done_q;
  logic                    done_d;
  logic [LOAD_STATE_N-1:0] st_oh;

  // Response for the load in flight
  assign rsp_done = rvalid_i && rsp_wait_q;

  always_comb begin
    state_d = state_q;
    req_set = 1'b0;
    done_d  = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOAD_META;
          req_set = 1'b1;
        end
      end
      LOAD_META: begin
        if (rsp_done) begin
          state_d = LOAD_X;
          req_set = 1'b1;
        end
      end
      LOAD_X: begin
        if (rsp_done) begin
          state_d = LOAD_Y;
          req_set = 1'b1;
        end
      end
      LOAD_Y: begin
        if (rsp_done) begin
          state_d = WAIT_PAIR;
        end
      end
      WAIT_PAIR: begin
        // Next load waits for the engine to take the pair
        if (pair_accept_i) begin
          if (!last_elem_i) begin
            state_d = LOAD_Y;
            req_set = 1'b1;
          end else if (!last_x_i) begin
            state_d = LOAD_X;
            req_set = 1'b1;
          end else begin
            state_d = IDLE;
            done_d  = 1'b1;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      pend_q     <= 1'b0;
      rsp_wait_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      // One request per load that drops once granted
      if (req_set) begin
        pend_q <= 1'b1;
      end else if (gnt_i) begin
        pend_q <= 1'b0;
      end
      if (gnt_i && pend_q) begin
        rsp_wait_q <= 1'b1;
      end else if (rvalid_i) begin
        rsp_wait_q <= 1'b0;
      end
    end
  end

  assign st_oh = LOAD_STATE_N'(1) << state_q;

  assign state_o = state_q;
  assign req_o   = pend_q;
  assign busy_o  = !st_oh[IDLE];
  assign done_o  = done_q;

  // Single outstanding read on the port
  a_req_while_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o |-> !rsp_wait_q
  );

  // No Y load overlaps a pair that waits for the engine
  a_wait_pair_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    st_oh[WAIT_PAIR] |-> !(req_o || gnt_i || rvalid_i)
  );

endmodule

// ==== source/operand_buffers.sv ====
// Metadata register, X buffer with element select, Y register with lane mask
`timescale 1ns/10ps

module operand_buffers (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  streamer_pkg::load_state_e       state_i,
  input  logic                            rvalid_i,
  input  logic [mem_port_pkg::MEM_DW-1:0] rdata_i,
  input  logic                            pair_ready_i,
  output streamer_pkg::operand_pair_t     pair_o,
  output logic                            pair_valid_o,
  output logic                            pair_accept_o,
  output logic [mem_port_pkg::MEM_DW-1:0] meta_o
);

  import mem_port_pkg::*;
  import streamer_pkg::*;

  logic [MEM_DW-1:0]     meta_q;
  logic [MEM_DW-1:0]     x_buf_q;
  logic [MEM_DW-1:0]     y_q;
  logic                  valid_q;
  logic [ELEM_IDX_W-1:0] elem_idx_q;
  logic [LANE_CNT_W-1:0] lane_raw;
  logic [LANE_CNT_W-1:0] lane_cnt;
  logic [X_ITEM_W-1:0]   x_sel;
  logic [MEM_DW-1:0]     y_masked;
  logic                  accept;

  assign accept = valid_q && pair_ready_i;

  // Control state and metadata
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q     <= '0;
      valid_q    <= 1'b0;
      elem_idx_q <= '0;
    end else begin
      if (rvalid_i && state_i == LOAD_META) begin
        meta_q <= rdata_i;
      end
      // A fresh X word starts again at element 0
      if (rvalid_i && state_i == LOAD_X) begin
        elem_idx_q <= '0;
      end else if (accept) begin
        elem_idx_q <= elem_idx_q + ELEM_IDX_W'(1);
      end
      if (rvalid_i && state_i == LOAD_Y) begin
        valid_q <= 1'b1;
      end else if (accept) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Operand payload
  always_ff @(posedge clk_i) begin
    if (rvalid_i && state_i == LOAD_X) begin
      x_buf_q <= rdata_i;
    end
    if (rvalid_i && state_i == LOAD_Y) begin
      y_q <= rdata_i;
    end
  end

  // Lane count clamped to the lanes present in a word
  assign lane_raw = meta_q[LANE_CNT_W-1:0];
  assign lane_cnt = (lane_raw > LANE_CNT_W'(Y_LANES)) ? LANE_CNT_W'(Y_LANES) : lane_raw;

  assign x_sel = x_buf_q[elem_idx_q*X_ITEM_W +: X_ITEM_W];

  always_comb begin
    y_masked = y_q;
    for (int i = 0; i < Y_LANES; i++) begin
      if (i >= lane_cnt) begin
        y_masked[i*Y_ITEM_W +: Y_ITEM_W] = '0;
      end
    end
  end

  assign pair_o.x      = x_sel;
  assign pair_o.y      = y_masked;
  assign pair_valid_o  = valid_q;
  assign pair_accept_o = accept;
  assign meta_o        = meta_q;

  // Stalled pair is held unchanged until taken
  a_pair_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pair_valid_o && !pair_ready_i) |=> (pair_valid_o && $stable(pair_o))
  );

endmodule

// ==== source/operand_streamer.sv ====
// Operand streamer top level: load FSM, address generator, operand buffers
`timescale 1ns/10ps

module operand_streamer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  streamer_pkg::job_cfg_t          job_i,
  output logic                            busy_o,
  output logic                            done_o,
  output mem_port_pkg::mem_req_t          mem_req_o,
  input  mem_port_pkg::mem_rsp_t          mem_rsp_i,
  output streamer_pkg::operand_pair_t     pair_o,
  output logic                            pair_valid_o,
  input  logic                            pair_ready_i,
  output logic [mem_port_pkg::MEM_DW-1:0] meta_o
);

  import mem_port_pkg::*;
  import streamer_pkg::*;

  load_state_e       state;
  logic              req;
  logic [MEM_AW-1:0] addr;
  logic              last_x;
  logic              last_elem;
  logic              pair_accept;

  load_fsm load_fsm_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .rvalid_i      (mem_rsp_i.rvalid),
    .gnt_i         (mem_rsp_i.gnt),
    .pair_accept_i (pair_accept),
    .last_x_i      (last_x),
    .last_elem_i   (last_elem),
    .state_o       (state),
    .req_o         (req),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  load_addr_gen load_addr_gen_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .job_i       (job_i),
    .state_i     (state),
    .gnt_i       (mem_rsp_i.gnt),
    .addr_o      (addr),
    .last_x_o    (last_x),
    .last_elem_o (last_elem)
  );

  operand_buffers operand_buffers_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .state_i       (state),
    .rvalid_i      (mem_rsp_i.rvalid),
    .rdata_i       (mem_rsp_i.rdata),
    .pair_ready_i  (pair_ready_i),
    .pair_o        (pair_o),
    .pair_valid_o  (pair_valid_o),
    .pair_accept_o (pair_accept),
    .meta_o        (meta_o)
  );

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = addr;

endmodule

// ==== tests/tb_memory.sv ====
// Behavioral read memory with random grant and response latency
// Word contents are computed from the address
`timescale 1ns/10ps

module tb_memory (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_port_pkg::mem_req_t req_i,
  output mem_port_pkg::mem_rsp_t rsp_o,
  output int                     err_cnt_o
);

  import mem_port_pkg::*;

  localparam logic [31:0] SEED = 32'hbe61_48fa;

  logic [31:0]       rng;
  logic              busy;
  logic              waiting;
  int                gnt_wait;
  int                rsp_wait;
  logic [MEM_AW-1:0] addr_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Same contents as the testbench reference
  function automatic logic [MEM_DW-1:0] word_at(input logic [MEM_AW-1:0] a);
    return xorshift32(32'(a) ^ SEED);
  endfunction

  initial begin
    rsp_o     = '0;
    err_cnt_o = 0;
    rng       = SEED;
    busy      = 1'b0;
    waiting   = 1'b0;
    gnt_wait  = 0;
    rsp_wait  = 0;
    addr_q    = '0;
    forever begin
      @(posedge clk_i);
      #1;
      rsp_o.gnt    = 1'b0;
      rsp_o.rvalid = 1'b0;
      if (!rst_ni) begin
        busy    = 1'b0;
        waiting = 1'b0;
      end else if (busy) begin
        if (req_i.req) begin
          err_cnt_o++;
          $display("Memory protocol violation at time %0t: request while a read is outstanding",
                   $time);
        end
        rsp_wait--;
        if (rsp_wait == 0) begin
          rsp_o.rvalid = 1'b1;
          rsp_o.rdata  = word_at(addr_q);
          busy         = 1'b0;
        end
      end else if (req_i.req) begin
        // Grant delay is drawn once per request
        if (!waiting) begin
          rng      = xorshift32(rng);
          gnt_wait = int'(rng % 32'd3);
          waiting  = 1'b1;
          addr_q   = req_i.addr;
        end else if (req_i.addr != addr_q) begin
          err_cnt_o++;
          $display("Memory protocol violation at time %0t: address changed before grant", $time);
        end
        if (gnt_wait == 0) begin
          rsp_o.gnt = 1'b1;
          addr_q    = req_i.addr;
          rng       = xorshift32(rng);
          rsp_wait  = 1 + int'(rng % 32'd3);
          busy      = 1'b1;
          waiting   = 1'b0;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

endmodule

// ==== tests/tb_operand_streamer.sv ====
// Testbench for the operand streamer
// Jobs, reference model, pair monitor, random back-pressure and watchdog
`timescale 1ns/10ps

module tb_operand_streamer;

  import mem_port_pkg::*;
  import streamer_pkg::*;

  localparam logic [31:0] SEED       = 32'hbe61_48fa;
  localparam int          CLK_PERIOD = 10;
  localparam int          NUM_JOBS   = 10;
  // X words per job in run order
  localparam int JOB_X_WORDS [NUM_JOBS] = '{1, 1, 1, 1, 1, 5, 6, 2, 3, 2};
  localparam int LANE_TESTS [4] = '{0, 2, 4, 7};

  logic              clk;
  logic              rst_n;
  logic              start;
  job_cfg_t          job;
  logic              busy;
  logic              done;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  operand_pair_t     pair;
  logic              pair_valid;
  logic              pair_ready;
  logic [MEM_DW-1:0] meta;

  job_cfg_t          cur_job;
  int                pair_idx;
  int                done_cnt;
  int                check_cnt;
  int                err_cnt;
  int                mem_err_cnt;
  logic              rand_ready;
  logic [31:0]       rng;
  logic              stalled;
  operand_pair_t     stall_pair;
  logic              done_prev;

  operand_streamer operand_streamer_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .start_i      (start),
    .job_i        (job),
    .busy_o       (busy),
    .done_o       (done),
    .mem_req_o    (mem_req),
    .mem_rsp_i    (mem_rsp),
    .pair_o       (pair),
    .pair_valid_o (pair_valid),
    .pair_ready_i (pair_ready),
    .meta_o       (meta)
  );

  tb_memory memory_inst (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (mem_req),
    .rsp_o     (mem_rsp),
    .err_cnt_o (mem_err_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [MEM_DW-1:0] mem_word(input logic [MEM_AW-1:0] a);
    return xorshift32(32'(a) ^ SEED);
  endfunction

  // Expected pair k of a job, from the memory contents
  function automatic operand_pair_t expected_pair(input job_cfg_t j, input int k);
    operand_pair_t     p;
    logic [MEM_DW-1:0] x_word;
    logic [MEM_DW-1:0] y_word;
    logic [MEM_DW-1:0] meta_word;
    int                lanes;
    meta_word = mem_word(j.meta_addr);
    lanes     = int'(meta_word[2:0]);
    if (lanes > Y_LANES) begin
      lanes = Y_LANES;
    end
    x_word = mem_word(j.x_addr + MEM_AW'(k / X_ELEMS_PER_WORD));
    y_word = mem_word(j.y_addr + MEM_AW'(k));
    for (int i = lanes; i < Y_LANES; i++) begin
      y_word[i*Y_ITEM_W +: Y_ITEM_W] = '0;
    end
    p.x = x_word[(k % X_ELEMS_PER_WORD)*X_ITEM_W +: X_ITEM_W];
    p.y = y_word;
    return p;
  endfunction

  // First address at or after from whose word carries the wanted lane count
  function automatic logic [MEM_AW-1:0] find_meta_addr(input int lanes,
                                                        input logic [MEM_AW-1:0] from);
    logic [MEM_AW-1:0] a;
    logic [MEM_DW-1:0] w;
    a = from;
    for (int n = 0; n < 4096; n++) begin
      w = mem_word(a);
      if (int'(w[2:0]) == lanes) begin
        return a;
      end
      a = a + MEM_AW'(1);
    end
    return from;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Called at 1 ns after a rising edge; returns at the same point after done
  task automatic run_job(input job_cfg_t j, input logic random_ready, input logic poke_busy);
    job_cfg_t other;
    int       done_before;
    other.meta_addr = j.meta_addr + MEM_AW'(16'h0100);
    other.x_addr    = j.x_addr + MEM_AW'(16'h0200);
    other.y_addr    = j.y_addr + MEM_AW'(16'h0300);
    other.x_words   = XCNT_W'(1);
    done_before     = done_cnt;
    cur_job         = j;
    pair_idx        = 0;
    rand_ready      = random_ready;
    job             = j;
    start           = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (poke_busy) begin
      // A second start during the job must be ignored
      repeat (3) @(posedge clk);
      #1;
      check_value(64'(busy), 64'(1), "busy_o before ignored start");
      job   = other;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      job   = j;
    end
    while (done_cnt == done_before) begin
      @(posedge clk);
    end
    #1;
    check_value(64'(done_cnt), 64'(done_before + 1), "done pulses for job");
    check_value(64'(busy), 64'(0), "busy_o after done");
    check_value(64'(done), 64'(0), "done_o after pulse");
    rand_ready = 1'b0;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : ready_drive
    forever begin
      @(posedge clk);
      #1;
      if (rand_ready) begin
        rng        = xorshift32(rng);
        pair_ready = rng[0];
      end else begin
        pair_ready = 1'b1;
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (stalled) begin
        check_value(64'(pair_valid), 64'(1), "pair_valid_o while stalled");
        check_value(64'(pair), 64'(stall_pair), "pair_o while stalled");
      end
      if (pair_valid && pair_ready) begin
        check_value(64'(pair), 64'(expected_pair(cur_job, pair_idx)),
                    $sformatf("pair %0d", pair_idx));
        check_value(64'(meta), 64'(mem_word(cur_job.meta_addr)), "meta_o");
        pair_idx = pair_idx + 1;
      end
      if (done) begin
        done_cnt++;
        check_value(64'(busy), 64'(0), "busy_o in done cycle");
        check_value(64'(done_prev), 64'(0), "done_o pulse length");
        check_value(64'(pair_idx), 64'(int'(cur_job.x_words) * X_ELEMS_PER_WORD),
                    "pairs at done");
      end
      stalled    = pair_valid && !pair_ready;
      stall_pair = pair;
      done_prev  = done;
    end
  end

  initial begin : watchdog
    int limit;
    limit = 1000;
    for (int i = 0; i < NUM_JOBS; i++) begin
      limit += 40 * JOB_X_WORDS[i] * X_ELEMS_PER_WORD;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Checks: %0d, value errors: %0d, memory protocol errors: %0d",
             check_cnt, err_cnt, mem_err_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    job_cfg_t          j;
    logic [MEM_AW-1:0] meta_a;
    rst_n      = 1'b0;
    start      = 1'b0;
    job        = '0;
    pair_ready = 1'b1;
    rand_ready = 1'b0;
    rng        = SEED;
    cur_job    = '0;
    pair_idx   = 0;
    done_cnt   = 0;
    check_cnt  = 0;
    err_cnt    = 0;
    stalled    = 1'b0;
    stall_pair = '0;
    done_prev  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value(64'(mem_req.req), 64'(0), "mem req after reset");
    check_value(64'(pair_valid), 64'(0), "pair_valid_o after reset");
    check_value(64'(busy), 64'(0), "busy_o after reset");
    check_value(64'(done), 64'(0), "done_o after reset");
    check_value(64'(meta), 64'(0), "meta_o after reset");

    // Single X word, ready held high
    j = '{meta_addr: 16'h0010, x_addr: 16'h1000, y_addr: 16'h2000,
          x_words: XCNT_W'(JOB_X_WORDS[0])};
    run_job(j, 1'b0, 1'b0);

    // Lane counts 0, 2, 4 and 7
    for (int i = 0; i < 4; i++) begin
      meta_a = find_meta_addr(LANE_TESTS[i], MEM_AW'(16'h0100 + i * 64));
      j = '{meta_addr: meta_a, x_addr: MEM_AW'(16'h1100 + i * 8),
            y_addr: MEM_AW'(16'h2100 + i * 8), x_words: XCNT_W'(JOB_X_WORDS[1 + i])};
      run_job(j, 1'b0, 1'b0);
    end

    // Five X words across word boundaries
    j = '{meta_addr: 16'h0300, x_addr: 16'h3000, y_addr: 16'h4000,
          x_words: XCNT_W'(JOB_X_WORDS[5])};
    run_job(j, 1'b0, 1'b0);

    // Random back-pressure
    j = '{meta_addr: 16'h0400, x_addr: 16'h3100, y_addr: 16'h4100,
          x_words: XCNT_W'(JOB_X_WORDS[6])};
    run_job(j, 1'b1, 1'b0);

    // Back-to-back jobs with a start while busy
    for (int i = 0; i < 3; i++) begin
      j = '{meta_addr: MEM_AW'(16'h0500 + i * 16), x_addr: MEM_AW'(16'h5000 + i * 256),
            y_addr: MEM_AW'(16'h6000 + i * 256), x_words: XCNT_W'(JOB_X_WORDS[7 + i])};
      run_job(j, 1'(i % 2), 1'b1);
    end

    repeat (5) @(posedge clk);
    #1;
    check_value(64'(done_cnt), 64'(NUM_JOBS), "total done pulses");
    $display("Checks: %0d, value errors: %0d, memory protocol errors: %0d",
             check_cnt, err_cnt, mem_err_cnt);
    if (err_cnt == 0 && mem_err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
source/mem_port_pkg.sv
source/streamer_pkg.sv
source/load_addr_gen.sv
source/load_fsm.sv
source/operand_buffers.sv
source/operand_streamer.sv
tests/tb_memory.sv
tests/tb_operand_streamer.sv

// ==== run.sh ====
#!/bin/sh
# Build the operand streamer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_operand_streamer -f sources.f

out=$(./obj_dir/Vtb_operand_streamer)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
